// File: joybus_controller.f
+incdir+.
joybus_pkg.sv
joybus_rx.sv
joybus_crc.sv
joybus_responder.sv
joybus_line_arbiter.sv
joybus_tx.sv
joybus_controller.sv
tb_joybus_controller.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/100ps \
    -f joybus_controller.f \
    --top-module tb_joybus_controller \
    -o sim_joybus
./obj_dir/sim_joybus | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: tb_joybus_controller.sv
`timescale 1ns/100ps
`include "joybus_defs.svh"

module tb_joybus_controller;
    import joybus_pkg::*;

    localparam int LEVEL = `JOYBUS_LEVEL_CYCLES;
    localparam int CELL = 4 * LEVEL;
    localparam int NDATA = `JOYBUS_WRITE_DATA_BYTES;
    // reply starts about 45 cycles after the host stop bit
    localparam int REPLY_TIMEOUT = 4 * `JOYBUS_IDLE_CYCLES + 2 * `JOYBUS_TURNAROUND;
    // long enough to catch a whole 4 byte reply
    localparam int SILENCE = 16 * `JOYBUS_IDLE_CYCLES;
    // info reply 05 00 02 in the top three bytes
    localparam logic [31:0] INFO_WORD = 32'h05000200;

    logic sample_clk;
    logic crc_reset;
    logic host_low;
    logic line_in;
    logic line_drive_low;
    buttons_t button_state;
    stick_t stick_state;

    logic [31:0] lfsr_state;
    joybus_byte_t frame_q[$];
    logic [31:0] reply_word;
    int reply_bits;
    int value_errors;
    int protocol_errors;

    // open-drain wire low when either side pulls
    assign line_in = ~(host_low | line_drive_low);

    joybus_controller joybus_controller_inst (
        .sample_clk     (sample_clk),
        .crc_reset      (crc_reset),
        .line_in        (line_in),
        .button_state   (button_state),
        .stick_state    (stick_state),
        .line_drive_low (line_drive_low)
    );

    initial begin
        sample_clk = 1'b0;
        forever #2 sample_clk = ~sample_clk;
    end

    // galois lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic random_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic random_byte(output joybus_byte_t b);
        logic [31:0] v;
        random_bits(8, v);
        b = v[7:0];
    endtask

    // expected write checksum over the data msb first with eight zero bits appended
    function automatic joybus_byte_t model_crc(input logic [8*NDATA-1:0] msg);
        joybus_byte_t crc;
        logic top;
        logic din;
        int i;
        crc = 8'h00;
        for (i = 0; i < 8 * NDATA + 8; i++) begin
            din = msg[8*NDATA-1];
            msg = msg << 1;
            top = crc[7];
            crc = {crc[6:0], din};
            if (top) begin
                crc = crc ^ `JOYBUS_CRC_POLY;
            end
        end
        return crc;
    endfunction

    task automatic check_byte(input string name, input joybus_byte_t got,
                              input joybus_byte_t exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_len(input string name, input reply_len_t got, input reply_len_t exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    // one host level held for LEVEL cycles
    task automatic drive_level(input logic low);
        @(posedge sample_clk);
        host_low <= low;
        repeat (LEVEL - 1) @(posedge sample_clk);
    endtask

    // 0 is L,L,L,H and 1 is L,H,H,H
    task automatic send_bit(input logic b);
        drive_level(1'b1);
        drive_level(~b);
        drive_level(~b);
        drive_level(1'b0);
    endtask

    task automatic send_frame();
        joybus_byte_t b;
        int k;
        int i;
        for (k = 0; k < frame_q.size(); k++) begin
            b = frame_q[k];
            for (i = 0; i < 8; i++) begin
                send_bit(b[7]);
                b = b << 1;
            end
        end
        // host stop bit L,H,H then the line stays high
        drive_level(1'b1);
        drive_level(1'b0);
        drive_level(1'b0);
    endtask

    task automatic send_command(input joybus_byte_t cmd);
        frame_q.delete();
        frame_q.push_back(cmd);
        send_frame();
    endtask

    // first low level of a reply
    task automatic wait_drive(output logic seen);
        int cnt;
        cnt = 0;
        @(negedge sample_clk);
        while (!line_drive_low && cnt < REPLY_TIMEOUT) begin
            @(negedge sample_clk);
            cnt++;
        end
        seen = line_drive_low;
        if (!seen) begin
            $display("no reply started within %0d cycles", REPLY_TIMEOUT);
            protocol_errors++;
        end
    endtask

    // one level of low time is a 1, three levels a 0 and two levels the stop
    task automatic read_reply(output logic got);
        int low_cnt;
        int high_cnt;
        logic done;
        reply_word = '0;
        reply_bits = 0;
        wait_drive(got);
        done = !got;
        while (!done) begin
            low_cnt = 0;
            while (line_drive_low && low_cnt < CELL) begin
                @(negedge sample_clk);
                low_cnt++;
            end
            high_cnt = 0;
            while (!line_drive_low && high_cnt < CELL) begin
                @(negedge sample_clk);
                high_cnt++;
            end
            if (low_cnt == 2 * LEVEL) begin
                done = 1'b1;
                // nothing may follow the stop cell
                if (high_cnt != CELL) begin
                    $display("line pulled low again right after the stop cell");
                    protocol_errors++;
                end
            end else if ((low_cnt == LEVEL || low_cnt == 3 * LEVEL) &&
                         (low_cnt + high_cnt == CELL) && reply_bits < 32) begin
                reply_word = {reply_word[30:0], (low_cnt == LEVEL)};
                reply_bits++;
            end else begin
                $display("illegal reply cell after %0d bits, low %0d cycles, high %0d cycles",
                         reply_bits, low_cnt, high_cnt);
                protocol_errors++;
                done = 1'b1;
            end
        end
    endtask

    task automatic expect_reply(input reply_len_t exp_len, input logic [31:0] exp_word);
        logic got;
        logic [31:0] got_word;
        logic [31:0] want_word;
        reply_len_t got_len;
        int i;
        read_reply(got);
        if (got) begin
            if (reply_bits % 8 != 0) begin
                $display("reply stopped after %0d bits, not a whole byte", reply_bits);
                protocol_errors++;
            end
            got_len = reply_len_t'(reply_bits / 8);
            check_len("reply_length", got_len, exp_len);
            // first byte on the wire moved to the top
            got_word = reply_word << (32 - reply_bits);
            want_word = exp_word;
            for (i = 0; i < int'(exp_len) && i < int'(got_len); i++) begin
                check_byte($sformatf("reply_byte[%0d]", i), got_word[31:24], want_word[31:24]);
                got_word = got_word << 8;
                want_word = want_word << 8;
            end
        end
    endtask

    task automatic expect_silence();
        int cnt;
        logic seen;
        seen = 1'b0;
        for (cnt = 0; cnt < SILENCE; cnt++) begin
            @(negedge sample_clk);
            if (line_drive_low) begin
                seen = 1'b1;
            end
        end
        if (seen) begin
            $display("line_drive_low went active where no reply is due");
            protocol_errors++;
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [8*NDATA-1:0] data_bits;
        joybus_byte_t b;
        joybus_byte_t code;
        buttons_t btn;
        stick_t stk;
        logic seen;
        int n;
        int i;
        lfsr_state = 32'h8548;
        value_errors = 0;
        protocol_errors = 0;
        crc_reset <= 1'b1;
        host_low <= 1'b0;
        button_state <= '0;
        stick_state <= '0;
        repeat (8) @(posedge sample_clk);
        crc_reset <= 1'b0;
        repeat (CELL) @(posedge sample_clk);

        // info and reset give the device id
        send_command(`JOYBUS_CMD_INFO);
        expect_reply(3'd3, INFO_WORD);
        send_command(`JOYBUS_CMD_RESET);
        expect_reply(3'd3, INFO_WORD);

        // status reply carries buttons then stick x then stick y
        for (n = 0; n < 12; n++) begin
            random_bits(32, r);
            btn = r[31:16];
            stk = r[15:0];
            @(posedge sample_clk);
            button_state <= btn;
            stick_state <= stk;
            send_command(`JOYBUS_CMD_STATUS);
            expect_reply(3'd4, {btn, stk});
        end

        // full writes answer with a single crc byte
        for (n = 0; n < 3; n++) begin
            frame_q.delete();
            frame_q.push_back(`JOYBUS_CMD_WRITE);
            data_bits = '0;
            for (i = 0; i < 2 + NDATA; i++) begin
                random_byte(b);
                frame_q.push_back(b);
                if (i >= 2) begin
                    data_bits = {data_bits[8*NDATA-9:0], b};
                end
            end
            send_frame();
            expect_reply(3'd1, {model_crc(data_bits), 24'h000000});
        end

        // read, unknown codes and a short write stay silent
        send_command(8'h02);
        expect_silence();
        for (n = 0; n < 4; n++) begin
            random_byte(code);
            if (code == `JOYBUS_CMD_INFO || code == `JOYBUS_CMD_STATUS ||
                code == `JOYBUS_CMD_WRITE || code == `JOYBUS_CMD_RESET) begin
                code = code ^ 8'h40;
            end
            send_command(code);
            expect_silence();
        end
        frame_q.delete();
        frame_q.push_back(`JOYBUS_CMD_WRITE);
        for (i = 0; i < 1 + NDATA; i++) begin
            random_byte(b);
            frame_q.push_back(b);
        end
        send_frame();
        expect_silence();

        // host talks over a status reply while rx is blind
        random_bits(32, r);
        btn = r[31:16];
        stk = r[15:0];
        @(posedge sample_clk);
        button_state <= btn;
        stick_state <= stk;
        send_command(`JOYBUS_CMD_STATUS);
        fork
            expect_reply(3'd4, {btn, stk});
            begin
                wait_drive(seen);
                if (seen) begin
                    send_command(`JOYBUS_CMD_INFO);
                end
            end
        join
        expect_silence();
        send_command(`JOYBUS_CMD_INFO);
        expect_reply(3'd3, INFO_WORD);

        // reset in the middle of a reply
        send_command(`JOYBUS_CMD_STATUS);
        wait_drive(seen);
        if (seen) begin
            repeat (5 * CELL) @(posedge sample_clk);
            crc_reset <= 1'b1;
            repeat (8) @(posedge sample_clk);
            crc_reset <= 1'b0;
            @(negedge sample_clk);
            if (line_drive_low) begin
                $display("line_drive_low still active after a reset during a reply");
                protocol_errors++;
            end
        end
        repeat (2 * CELL) @(posedge sample_clk);
        send_command(`JOYBUS_CMD_INFO);
        expect_reply(3'd3, INFO_WORD);

        $display("value errors %0d, protocol errors %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: joybus_controller.sv
`timescale 1ns/100ps

module joybus_controller (
    input  logic                 sample_clk,
    input  logic                 crc_reset,
    input  logic                 line_in,
    input  joybus_pkg::buttons_t button_state,
    input  joybus_pkg::stick_t   stick_state,
    output logic                 line_drive_low
);
    import joybus_pkg::*;

    rx_event_t rx_event;
    joybus_byte_t crc_value;
    logic crc_done;
    reply_t reply_req;
    reply_t tx_reply;
    logic tx_drive_low;
    logic tx_busy;
    logic rx_enable;

    // host side, bytes and frame end
    joybus_rx rx_inst (
        .sample_clk (sample_clk),
        .crc_reset  (crc_reset),
        .line_in    (line_in),
        .rx_enable  (rx_enable),
        .rx_event   (rx_event)
    );

    joybus_crc crc_inst (
        .sample_clk (sample_clk),
        .crc_reset  (crc_reset),
        .rx_event   (rx_event),
        .crc_value  (crc_value),
        .crc_done   (crc_done)
    );

    joybus_responder responder_inst (
        .sample_clk   (sample_clk),
        .crc_reset    (crc_reset),
        .rx_event     (rx_event),
        .crc_value    (crc_value),
        .crc_done     (crc_done),
        .button_state (button_state),
        .stick_state  (stick_state),
        .reply        (reply_req)
    );

    // wire ownership and turnaround
    joybus_line_arbiter arbiter_inst (
        .sample_clk     (sample_clk),
        .crc_reset      (crc_reset),
        .reply_req      (reply_req),
        .tx_busy        (tx_busy),
        .tx_drive_low   (tx_drive_low),
        .tx_reply       (tx_reply),
        .rx_enable      (rx_enable),
        .line_drive_low (line_drive_low)
    );

    joybus_tx tx_inst (
        .sample_clk   (sample_clk),
        .crc_reset    (crc_reset),
        .tx_reply     (tx_reply),
        .tx_drive_low (tx_drive_low),
        .tx_busy      (tx_busy)
    );

endmodule

// File: joybus_tx.sv
`timescale 1ns/100ps
`include "joybus_defs.svh"

module joybus_tx (
    input  logic               sample_clk,
    input  logic               crc_reset,
    input  joybus_pkg::reply_t tx_reply,
    output logic               tx_drive_low,
    output logic               tx_busy
);
    import joybus_pkg::*;

    localparam int LEVEL_W = (`JOYBUS_LEVEL_CYCLES > 1) ? $clog2(`JOYBUS_LEVEL_CYCLES) : 1;
    localparam logic [LEVEL_W-1:0] LEVEL_LAST = LEVEL_W'(`JOYBUS_LEVEL_CYCLES - 1);
    // drive-low per level, bit i is level i
    localparam logic [3:0] CELL_ZERO = 4'b0111;
    localparam logic [3:0] CELL_ONE = 4'b0001;
    localparam logic [3:0] CELL_STOP = 4'b0011;

    tx_state_t state;
    logic [31:0] payload_sr;
    logic [5:0] bits_left;
    logic [3:0] cell_pat;
    logic [LEVEL_W-1:0] cyc_cnt;
    logic [1:0] level_idx;
    logic cell_end;

    assign cell_end = (cyc_cnt == LEVEL_LAST) && (level_idx == 2'd3);
    assign tx_busy = (state != tx_idle);

    // load is level 0 of a data cell, always low
    always_comb begin
        case (state)
            tx_load: tx_drive_low = 1'b1;
            tx_levels: tx_drive_low = cell_pat[level_idx];
            tx_stop: tx_drive_low = CELL_STOP[level_idx];
            default: tx_drive_low = 1'b0;
        endcase
    end

    always_ff @(posedge sample_clk) begin
        if (crc_reset) begin
            state <= tx_idle;
            bits_left <= '0;
            cyc_cnt <= '0;
            level_idx <= '0;
        end else begin
            // level and cycle position inside the cell
            if (state != tx_idle) begin
                if (cyc_cnt == LEVEL_LAST) begin
                    cyc_cnt <= '0;
                    level_idx <= level_idx + 2'd1;
                end else begin
                    cyc_cnt <= cyc_cnt + LEVEL_W'(1);
                end
            end

            case (state)
                tx_idle: begin
                    if (tx_reply.start) begin
                        payload_sr <= tx_reply.payload;
                        bits_left <= {tx_reply.length, 3'b000};
                        cyc_cnt <= '0;
                        level_idx <= '0;
                        // zero length sends only the stop cell
                        state <= (tx_reply.length == '0) ? tx_stop : tx_load;
                    end
                end
                tx_load: begin
                    // next data bit, msb of the top byte first
                    cell_pat <= payload_sr[31] ? CELL_ONE : CELL_ZERO;
                    payload_sr <= {payload_sr[30:0], 1'b0};
                    bits_left <= bits_left - 6'd1;
                    state <= tx_levels;
                end
                tx_levels: begin
                    if (cell_end) begin
                        state <= (bits_left != 6'd0) ? tx_load : tx_stop;
                    end
                end
                tx_stop: begin
                    if (cell_end) begin
                        state <= tx_idle;
                    end
                end
                default: state <= tx_idle;
            endcase
        end
    end

endmodule

// File: joybus_line_arbiter.sv
`timescale 1ns/100ps
`include "joybus_defs.svh"

module joybus_line_arbiter (
    input  logic               sample_clk,
    input  logic               crc_reset,
    input  joybus_pkg::reply_t reply_req,
    input  logic               tx_busy,
    input  logic               tx_drive_low,
    output joybus_pkg::reply_t tx_reply,
    output logic               rx_enable,
    output logic               line_drive_low
);
    import joybus_pkg::*;

    localparam int GAP_W = $clog2(`JOYBUS_TURNAROUND + 1);
    localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(`JOYBUS_TURNAROUND);

    logic gap_active;
    logic [GAP_W-1:0] gap_cnt;
    logic tx_owner;
    logic busy_prev;
    logic accept;
    logic grant_tx;
    reply_len_t held_len;
    logic [31:0] held_payload;

    // requests only land while the receiver owns the wire
    assign accept = reply_req.start && !gap_active && !tx_owner;
    assign grant_tx = gap_active && (gap_cnt == GAP_LAST);

    assign tx_reply.start = grant_tx;
    assign tx_reply.length = held_len;
    assign tx_reply.payload = held_payload;

    // receiver blind from grant until the stop cell is out
    assign rx_enable = ~(grant_tx | tx_owner);
    assign line_drive_low = tx_owner & tx_drive_low;

    always_ff @(posedge sample_clk) begin
        if (crc_reset) begin
            gap_active <= 1'b0;
            gap_cnt <= '0;
            tx_owner <= 1'b0;
            busy_prev <= 1'b0;
        end else begin
            busy_prev <= tx_busy;
            if (accept) begin
                gap_active <= 1'b1;
                gap_cnt <= GAP_W'(1);
            end else if (grant_tx) begin
                gap_active <= 1'b0;
                tx_owner <= 1'b1;
            end else if (gap_active) begin
                gap_cnt <= gap_cnt + GAP_W'(1);
            end
            // hand back on the falling edge of busy
            if (tx_owner && busy_prev && !tx_busy) begin
                tx_owner <= 1'b0;
            end
        end
    end

    always_ff @(posedge sample_clk) begin
        if (accept) begin
            held_len <= reply_req.length;
            held_payload <= reply_req.payload;
        end
    end

endmodule

// File: joybus_responder.sv
`timescale 1ns/100ps
`include "joybus_defs.svh"

module joybus_responder (
    input  logic                     sample_clk,
    input  logic                     crc_reset,
    input  joybus_pkg::rx_event_t    rx_event,
    input  joybus_pkg::joybus_byte_t crc_value,
    input  logic                     crc_done,
    input  joybus_pkg::buttons_t     button_state,
    input  joybus_pkg::stick_t       stick_state,
    output joybus_pkg::reply_t       reply
);
    import joybus_pkg::*;

    // command, address pair, then the data block
    localparam logic [5:0] WRITE_BYTES = 6'(`JOYBUS_WRITE_DATA_BYTES + 3);

    responder_state_t state;
    joybus_byte_t cmd;
    logic [5:0] byte_cnt;
    reply_len_t reply_len;
    logic [31:0] reply_payload;

    // start is a single cycle in the reply state
    assign reply.start = (state == rsp_reply);
    assign reply.length = reply_len;
    assign reply.payload = reply_payload;

    always_ff @(posedge sample_clk) begin
        if (crc_reset) begin
            state <= rsp_idle;
            byte_cnt <= '0;
            reply_len <= '0;
        end else begin
            case (state)
                rsp_idle: begin
                    // first byte of a frame is the command
                    if (rx_event.byte_valid) begin
                        cmd <= rx_event.data;
                        byte_cnt <= 6'd1;
                        state <= rsp_collect;
                    end
                end
                rsp_collect: begin
                    if (rx_event.byte_valid) begin
                        if (byte_cnt != 6'h3f) begin
                            byte_cnt <= byte_cnt + 6'd1;
                        end
                    end else if (rx_event.frame_end) begin
                        case (cmd)
                            `JOYBUS_CMD_INFO, `JOYBUS_CMD_RESET: begin
                                reply_len <= 3'd3;
                                reply_payload <= {`JOYBUS_INFO_BYTE0, `JOYBUS_INFO_BYTE1,
                                                  `JOYBUS_INFO_BYTE2, 8'h00};
                                state <= rsp_reply;
                            end
                            `JOYBUS_CMD_STATUS: begin
                                // inputs captured at frame end
                                reply_len <= 3'd4;
                                reply_payload <= {button_state, stick_state};
                                state <= rsp_reply;
                            end
                            `JOYBUS_CMD_WRITE: begin
                                // short or long writes are ignored
                                if (byte_cnt == WRITE_BYTES) begin
                                    state <= rsp_wait_crc;
                                end else begin
                                    state <= rsp_idle;
                                end
                            end
                            default: state <= rsp_idle;
                        endcase
                    end
                end
                rsp_wait_crc: begin
                    // flush finishes a fixed 8 cycles after frame end
                    if (crc_done) begin
                        reply_len <= 3'd1;
                        reply_payload <= {crc_value, 24'h000000};
                        state <= rsp_reply;
                    end
                end
                default: state <= rsp_idle;
            endcase
        end
    end

endmodule

// File: joybus_crc.sv
`timescale 1ns/100ps
`include "joybus_defs.svh"

module joybus_crc (
    input  logic                     sample_clk,
    input  logic                     crc_reset,
    input  joybus_pkg::rx_event_t    rx_event,
    output joybus_pkg::joybus_byte_t crc_value,
    output logic                     crc_done
);
    import joybus_pkg::*;

    // byte 0 is the command, bytes 1 and 2 the address
    localparam logic [5:0] FIRST_DATA = 6'd3;
    localparam logic [5:0] LAST_DATA = 6'(`JOYBUS_WRITE_DATA_BYTES + 2);

    logic [5:0] byte_cnt;
    joybus_byte_t data_sr;
    logic [3:0] bits_left;
    logic flushing;
    joybus_byte_t crc_reg;
    logic done_strobe;
    logic take_byte;

    // one step of the msb-first shift register
    function automatic joybus_byte_t crc_step(input joybus_byte_t crc, input logic din);
        joybus_byte_t shifted;
        shifted = {crc[6:0], din};
        return crc[7] ? (shifted ^ `JOYBUS_CRC_POLY) : shifted;
    endfunction

    assign take_byte = rx_event.byte_valid && (byte_cnt >= FIRST_DATA) &&
                       (byte_cnt <= LAST_DATA);
    assign crc_value = crc_reg;
    assign crc_done = done_strobe;

    always_ff @(posedge sample_clk) begin
        if (crc_reset) begin
            byte_cnt <= '0;
            bits_left <= '0;
            flushing <= 1'b0;
            crc_reg <= '0;
            done_strobe <= 1'b0;
        end else begin
            done_strobe <= 1'b0;
            if (rx_event.frame_end) begin
                // augmentation, first of eight zero bits right away
                crc_reg <= crc_step(crc_reg, 1'b0);
                data_sr <= '0;
                bits_left <= 4'd7;
                flushing <= 1'b1;
                byte_cnt <= '0;
            end else if (take_byte) begin
                data_sr <= rx_event.data;
                bits_left <= 4'd8;
            end else if (bits_left != 4'd0) begin
                crc_reg <= crc_step(crc_reg, data_sr[7]);
                data_sr <= {data_sr[6:0], 1'b0};
                bits_left <= bits_left - 4'd1;
                if (flushing && bits_left == 4'd1) begin
                    done_strobe <= 1'b1;
                    flushing <= 1'b0;
                end
            end else if (done_strobe) begin
                // result taken, start clean for the next frame
                crc_reg <= '0;
            end

            if (rx_event.byte_valid && byte_cnt != 6'h3f) begin
                byte_cnt <= byte_cnt + 6'd1;
            end
        end
    end

endmodule

// File: joybus_rx.sv
`timescale 1ns/100ps
`include "joybus_defs.svh"

module joybus_rx (
    input  logic                  sample_clk,
    input  logic                  crc_reset,
    input  logic                  line_in,
    input  logic                  rx_enable,
    output joybus_pkg::rx_event_t rx_event
);
    import joybus_pkg::*;

    // sample 2.5 levels after the falling edge
    localparam int SAMPLE_AT = (5 * `JOYBUS_LEVEL_CYCLES) / 2;
    localparam int SAMPLE_W = $clog2(SAMPLE_AT + 1);
    localparam int IDLE_W = $clog2(`JOYBUS_IDLE_CYCLES + 1);
    localparam logic [SAMPLE_W-1:0] SAMPLE_LAST = SAMPLE_W'(SAMPLE_AT);
    localparam logic [IDLE_W-1:0] IDLE_LAST = IDLE_W'(`JOYBUS_IDLE_CYCLES - 1);

    logic [1:0] line_sync;
    logic line_prev;
    logic line_s;
    logic falling;
    logic armed;
    logic [SAMPLE_W-1:0] sample_cnt;
    logic [2:0] bit_cnt;
    joybus_byte_t shift_byte;
    logic [IDLE_W-1:0] idle_cnt;
    logic seen_bit;
    logic byte_strobe;
    logic end_strobe;

    assign line_s = line_sync[1];
    assign falling = line_prev & ~line_s;

    assign rx_event.byte_valid = byte_strobe;
    assign rx_event.frame_end = end_strobe;
    assign rx_event.data = shift_byte;

    // two-flop synchroniser, idle line is high
    always_ff @(posedge sample_clk) begin
        if (crc_reset) begin
            line_sync <= 2'b11;
            line_prev <= 1'b1;
        end else begin
            line_sync <= {line_sync[0], line_in};
            line_prev <= line_s;
        end
    end

    always_ff @(posedge sample_clk) begin
        if (crc_reset || !rx_enable) begin
            // disabled while our own reply is on the wire
            armed <= 1'b0;
            sample_cnt <= '0;
            bit_cnt <= '0;
            idle_cnt <= '0;
            seen_bit <= 1'b0;
            byte_strobe <= 1'b0;
            end_strobe <= 1'b0;
        end else begin
            byte_strobe <= 1'b0;
            end_strobe <= 1'b0;

            // every cell opens with a low level
            if (falling) begin
                armed <= 1'b1;
                sample_cnt <= SAMPLE_W'(1);
            end else if (armed) begin
                if (sample_cnt == SAMPLE_LAST) begin
                    // low at the sample point is a 0
                    armed <= 1'b0;
                    seen_bit <= 1'b1;
                    shift_byte <= {shift_byte[6:0], line_s};
                    bit_cnt <= bit_cnt + 3'd1;
                    byte_strobe <= (bit_cnt == 3'd7);
                end else begin
                    sample_cnt <= sample_cnt + SAMPLE_W'(1);
                end
            end

            // long high stretch ends the frame
            if (line_s) begin
                if (seen_bit && idle_cnt == IDLE_LAST) begin
                    end_strobe <= 1'b1;
                    seen_bit <= 1'b0;
                    // stray stop bit and any partial byte dropped
                    bit_cnt <= '0;
                    idle_cnt <= '0;
                end else if (idle_cnt != IDLE_LAST) begin
                    idle_cnt <= idle_cnt + IDLE_W'(1);
                end
            end else begin
                idle_cnt <= '0;
            end
        end
    end

endmodule

// File: joybus_pkg.sv
package joybus_pkg;

    // one byte as it travels on the wire, msb first
    typedef logic [7:0] joybus_byte_t;

    // button word, first two bytes of a status reply
    typedef logic [15:0] buttons_t;

    // stick x byte over stick y byte
    typedef logic [15:0] stick_t;

    // reply byte count, 0 to 4
    typedef logic [2:0] reply_len_t;

    // receiver output, strobes last one cycle
    typedef struct packed {
        logic         byte_valid;
        logic         frame_end;
        joybus_byte_t data;
    } rx_event_t;

    // reply request, payload sent from the top byte down
    typedef struct packed {
        logic        start;
        reply_len_t  length;
        logic [31:0] payload;
    } reply_t;

    typedef enum logic [1:0] {
        rsp_idle,
        rsp_collect,
        rsp_wait_crc,
        rsp_reply
    } responder_state_t;

    typedef enum logic [1:0] {
        tx_idle,
        tx_load,
        tx_levels,
        tx_stop
    } tx_state_t;

endpackage

// File: joybus_defs.svh
`ifndef JOYBUS_DEFS_SVH
`define JOYBUS_DEFS_SVH

// sample_clk cycles per line level, four levels per bit cell
`define JOYBUS_LEVEL_CYCLES 2
// three bit cells of high line close a frame
`define JOYBUS_IDLE_CYCLES 24
// gap between frame end and the first reply level
`define JOYBUS_TURNAROUND 16

// info reply, standard controller with no pak
`define JOYBUS_INFO_BYTE0 8'h05
`define JOYBUS_INFO_BYTE1 8'h00
`define JOYBUS_INFO_BYTE2 8'h02

// host command codes
`define JOYBUS_CMD_INFO 8'h00
`define JOYBUS_CMD_STATUS 8'h01
`define JOYBUS_CMD_WRITE 8'h03
`define JOYBUS_CMD_RESET 8'hFF

// write payload size and data checksum polynomial
`define JOYBUS_WRITE_DATA_BYTES 32
`define JOYBUS_CRC_POLY 8'h85

`endif
